//--- bench/vec_golden.txt
// inst_word exp_data exp_vd exp_vxsat, config words (bit 23 set) carry zeros as expected values
// a line whose first word is ffffffff ends the list
3200c8 c8c8c8c8 1 0  // vmvi v1, 200
340064 64646464 2 0  // vmvi v2, 100
065000 2c2c2c2c 3 0  // vadd v3 = v1 + v2 wraps
08d000 90909090 4 0
1a5000 ffffffff 5 1  // vsaddu clamps at 255
2c8800 00000000 6 1  // vssubu clamps at 0
2e5000 64646464 7 0
800002 00000000 0 0  // vl = 2
320032 c8c83232 1 0  // tail lanes keep 200
164800 2c2c6464 3 0  // tail would overflow but reports old value
800007 00000000 0 0  // vl = 7 acts as 4
164800 ffff6464 3 1
2c5000 64640000 6 1
00f000 63636464 0 0
143800 c7c7c8c8 2 0
800003 00000000 0 0  // vl = 3
149000 c7ffffff 2 1
380001 90010101 4 0
800000 00000000 0 0  // vl = 0, no lane writes
1a9000 ffffffff 5 0
800004 00000000 0 0
2f1000 00000000 7 1
032000 20020202 1 0
1da000 f4650101 6 0
000800 83656666 0 0
ffffffff 00000000 0 0

//--- list.f
rtl/vec_pkg.sv
rtl/vec_cmd_queue.sv
rtl/vec_dispatch.sv
rtl/vec_lane.sv
rtl/vec_retire.sv
rtl/vec_backend_top.sv
bench/tb_clk_gen.sv
bench/vec_backend_tb.sv

//--- Makefile
VERILATOR := verilator
TOP       := vec_backend_tb
FILELIST  := list.f
FLAGS     := --binary --timing --assert -Wno-fatal
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qxF '** PASS **' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/vec_backend_tb.sv
`timescale 1ns/100ps

module vec_backend_tb;

  import vec_pkg::*;

  localparam int          clk_period_ns   = 10;
  localparam int          reset_cycles    = 5;
  localparam int          drive_dly_ns    = 1;
  localparam int          max_lines       = 64;
  localparam int          cycles_per_line = 40;
  localparam int          max_ack_delay   = 6;
  localparam int          idle_wait_max   = 10;
  localparam int          rearm_cycles    = 3;
  localparam logic [31:0] rand_seed       = 32'h3106;
  localparam logic [31:0] end_marker      = 32'hffff_ffff;
  localparam string       golden_file     = "bench/vec_golden.txt";

  logic      clk;
  logic      rst_n;
  logic      inst_req;
  vinst_u    inst;
  logic      inst_ack;
  logic      rt_req;
  elem_vec_t rt_data;
  vreg_idx_t rt_vd;
  logic      rt_vxsat;
  logic      rt_ack;
  logic      idle;

  // Four words per golden line
  logic [31:0] golden_mem [max_lines*4];
  vinst_u      inst_list [$];
  elem_vec_t   exp_data [$];
  vreg_idx_t   exp_vd [$];
  logic        exp_vxsat [$];

  int   n_lines      = 0;
  int   err_count    = 0;
  int   tests_run    = 0;
  int   tests_failed = 0;
  int   ack_count    = 0;
  logic ack_prev     = 1'b0;
  logic load_done    = 1'b0;

  tb_clk_gen #(
    .period_ns    (clk_period_ns),
    .reset_cycles (reset_cycles)
  ) u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  vec_backend_top dut0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst_req_i (inst_req),
    .inst_i     (inst),
    .inst_ack_o (inst_ack),
    .rt_req_o   (rt_req),
    .rt_data_o  (rt_data),
    .rt_vd_o    (rt_vd),
    .rt_vxsat_o (rt_vxsat),
    .rt_ack_i   (rt_ack),
    .idle_o     (idle)
  );

  task automatic check_data(input elem_vec_t got, input elem_vec_t exp, input int idx);
    if (got !== exp) begin
      $display("FAILED at %0d ns: record %0d data %08h, expected %08h", $time, idx, got, exp);
      err_count++;
    end
  endtask

  task automatic check_vd(input vreg_idx_t got, input vreg_idx_t exp, input int idx);
    if (got !== exp) begin
      $display("FAILED at %0d ns: record %0d vd %0d, expected %0d", $time, idx, got, exp);
      err_count++;
    end
  endtask

  task automatic check_vxsat(input logic got, input logic exp, input int idx);
    if (got !== exp) begin
      $display("FAILED at %0d ns: record %0d vxsat %b, expected %b", $time, idx, got, exp);
      err_count++;
    end
  endtask

  task automatic check_idle(input logic got, input logic exp, input string when);
    if (got !== exp) begin
      $display("FAILED at %0d ns: idle %b %s, expected %b", $time, got, when, exp);
      err_count++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (err_count != errs_before) begin
      tests_failed++;
      $display("test %0d %s: failed", tests_run, name);
    end else begin
      $display("test %0d %s: passed", tests_run, name);
    end
  endtask

  task automatic load_golden();
    int          i;
    logic [31:0] word;
    $readmemh(golden_file, golden_mem);
    i = 0;
    while (i < max_lines && golden_mem[4*i] != end_marker) begin
      word = golden_mem[4*i];
      inst_list.push_back(vinst_u'(word[23:0]));
      // Only arithmetic words (bit 23 clear) retire a record
      if (!word[23]) begin
        exp_data.push_back(golden_mem[4*i+1]);
        exp_vd.push_back(golden_mem[4*i+2][vreg_w-1:0]);
        exp_vxsat.push_back(golden_mem[4*i+3][0]);
      end
      i++;
    end
    n_lines = i;
    if (n_lines == 0) begin
      $display("the golden file holds no instructions");
      err_count++;
    end
  endtask

  // Scalar side of the intake handshake
  task automatic drive_intake();
    foreach (inst_list[i]) begin
      @(posedge clk);
      #(drive_dly_ns);
      inst     = inst_list[i];
      inst_req = 1'b1;
      do @(negedge clk); while (!inst_ack);
      @(posedge clk);
      #(drive_dly_ns);
      inst_req = 1'b0;
      do @(negedge clk); while (inst_ack);
    end
  endtask

  // Consumer with random ack latency
  task automatic collect_retire();
    int delay;
    int errs_before;
    for (int r = 0; r < exp_data.size(); r++) begin
      do @(negedge clk); while (!rt_req);
      delay = $urandom % (max_ack_delay + 1);
      repeat (delay) @(negedge clk);
      errs_before = err_count;
      check_data(rt_data, exp_data[r], r);
      check_vd(rt_vd, exp_vd[r], r);
      check_vxsat(rt_vxsat, exp_vxsat[r], r);
      @(posedge clk);
      #(drive_dly_ns);
      rt_ack = 1'b1;
      do @(negedge clk); while (rt_req);
      @(posedge clk);
      #(drive_dly_ns);
      rt_ack = 1'b0;
      report_test($sformatf("retire record %0d vd %0d", r, exp_vd[r]), errs_before);
    end
  endtask

  // Each intake word must be acknowledged exactly once
  always @(negedge clk) begin
    if (inst_ack && !ack_prev) begin
      ack_count++;
    end
    ack_prev = inst_ack;
  end

  initial begin
    int idle_wait;
    int errs_before;
    inst_req = 1'b0;
    inst     = '0;
    rt_ack   = 1'b0;
    void'($urandom(rand_seed));
    load_golden();
    load_done = 1'b1;

    @(posedge rst_n);
    @(negedge clk);
    errs_before = err_count;
    check_idle(idle, 1'b1, "after reset");
    report_test("idle after reset", errs_before);

    fork
      drive_intake();
      collect_retire();
    join

    errs_before = err_count;
    if (ack_count != n_lines) begin
      $display("intake acknowledged %0d times for %0d words", ack_count, n_lines);
      err_count++;
    end
    report_test("intake handshakes", errs_before);

    errs_before = err_count;
    idle_wait = 0;
    while (!idle && idle_wait < idle_wait_max) begin
      @(negedge clk);
      idle_wait++;
    end
    // A stray record would raise rt_req within two cycles of ack falling
    repeat (rearm_cycles) @(negedge clk);
    check_idle(idle, 1'b1, "after last record");
    if (rt_req) begin
      $display("an extra retire record was offered after the last expected one");
      err_count++;
    end
    report_test("idle after last record", errs_before);

    $display("tests run %0d, passed %0d, failed %0d, check errors %0d",
             tests_run, tests_run - tests_failed, tests_failed, err_count);
    if (err_count == 0 && tests_failed == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // Watchdog sized from the golden line count
  initial begin
    int limit_cycles;
    wait (load_done);
    limit_cycles = n_lines * cycles_per_line + reset_cycles;
    repeat (limit_cycles) @(posedge clk);
    $display("timeout: the run did not finish within %0d clock cycles", limit_cycles);
    $display("** FAIL **");
    $finish;
  end

endmodule

//--- bench/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int period_ns    = 10,
  parameter int reset_cycles = 5
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(period_ns / 2) clk_o = ~clk_o;
    end
  end

  // Release reset just after a rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (reset_cycles) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

endmodule

//--- rtl/vec_backend_top.sv
`timescale 1ns/100ps

module vec_backend_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               inst_req_i,
  input  vec_pkg::vinst_u    inst_i,
  output logic               inst_ack_o,
  output logic               rt_req_o,
  output vec_pkg::elem_vec_t rt_data_o,
  output vec_pkg::vreg_idx_t rt_vd_o,
  output logic               rt_vxsat_o,
  input  logic               rt_ack_i,
  output logic               idle_o
);

  import vec_pkg::*;

  logic                 q_valid;
  vinst_u               q_inst;
  logic                 q_pop;
  logic                 q_empty;
  logic                 rt_space;
  logic                 issue_valid;
  vfunct_t              issue_funct;
  vreg_idx_t            issue_vd;
  vreg_idx_t            issue_vs1;
  vreg_idx_t            issue_vs2;
  elem_t                issue_imm;
  logic [num_lanes-1:0] lane_en;
  logic [num_lanes-1:0] res_valid;
  logic [num_lanes-1:0] res_sat;
  elem_vec_t            res_data;
  vreg_idx_t            res_vd;
  logic [1:0]           pending;

  vec_cmd_queue u_queue (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst_req_i (inst_req_i),
    .inst_i     (inst_i),
    .inst_ack_o (inst_ack_o),
    .q_pop_i    (q_pop),
    .q_valid_o  (q_valid),
    .q_inst_o   (q_inst),
    .q_empty_o  (q_empty)
  );

  vec_dispatch u_dispatch (
    .clk           (clk),
    .rst_n         (rst_n),
    .q_valid_i     (q_valid),
    .q_inst_i      (q_inst),
    .q_pop_o       (q_pop),
    .rt_space_i    (rt_space),
    .issue_valid_o (issue_valid),
    .issue_funct_o (issue_funct),
    .issue_vd_o    (issue_vd),
    .issue_vs1_o   (issue_vs1),
    .issue_vs2_o   (issue_vs2),
    .issue_imm_o   (issue_imm),
    .lane_en_o     (lane_en)
  );

  generate
    for (genvar g = 0; g < num_lanes; g++) begin : g_lane
      vec_lane u_lane (
        .clk           (clk),
        .rst_n         (rst_n),
        .issue_valid_i (issue_valid),
        .lane_en_i     (lane_en[g]),
        .issue_funct_i (issue_funct),
        .issue_vd_i    (issue_vd),
        .issue_vs1_i   (issue_vs1),
        .issue_vs2_i   (issue_vs2),
        .issue_imm_i   (issue_imm),
        .res_valid_o   (res_valid[g]),
        .res_elem_o    (res_data[g*elem_w +: elem_w]),
        .res_sat_o     (res_sat[g])
      );
    end
  endgenerate

  // vd travels beside the lanes in step with res_valid
  always_ff @(posedge clk) begin
    if (issue_valid) begin
      res_vd <= issue_vd;
    end
  end

  vec_retire u_retire (
    .clk         (clk),
    .rst_n       (rst_n),
    .res_valid_i (res_valid[0]),
    .res_data_i  (res_data),
    .res_sat_i   (res_sat),
    .res_vd_i    (res_vd),
    .rt_space_o  (rt_space),
    .rt_req_o    (rt_req_o),
    .rt_data_o   (rt_data_o),
    .rt_vd_o     (rt_vd_o),
    .rt_vxsat_o  (rt_vxsat_o),
    .rt_ack_i    (rt_ack_i)
  );

  // Issued ops not yet acked on the retire port
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending <= 2'd0;
    end else begin
      case ({issue_valid, rt_req_o && rt_ack_i})
        2'b10:   pending <= pending + 1'b1;
        2'b01:   pending <= pending - 1'b1;
        default: pending <= pending;
      endcase
    end
  end

  assign idle_o = q_empty && !issue_valid && (pending == 2'd0) && !rt_ack_i;

  // Every lane answers exactly one cycle after issue
  a_lockstep: assert property (@(posedge clk) disable iff (!rst_n)
    res_valid == {num_lanes{$past(issue_valid)}});

endmodule

//--- rtl/vec_retire.sv
`timescale 1ns/100ps

module vec_retire (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          res_valid_i,
  input  vec_pkg::elem_vec_t            res_data_i,
  input  logic [vec_pkg::num_lanes-1:0] res_sat_i,
  input  vec_pkg::vreg_idx_t            res_vd_i,
  output logic                          rt_space_o,
  output logic                          rt_req_o,
  output vec_pkg::elem_vec_t            rt_data_o,
  output vec_pkg::vreg_idx_t            rt_vd_o,
  output logic                          rt_vxsat_o,
  input  logic                          rt_ack_i
);

  import vec_pkg::*;

  elem_vec_t  buf_data [2];
  vreg_idx_t  buf_vd [2];
  logic       buf_sat [2];
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;
  logic       req_q;
  logic       wait_q;
  logic       push;
  logic       pop;

  assign push = res_valid_i;
  assign pop  = req_q && rt_ack_i;

  // A lane result already in flight takes a slot
  assign rt_space_o = (count == 2'd0) || ((count == 2'd1) && !res_valid_i);

  always_ff @(posedge clk) begin
    if (push) begin
      buf_data[wr_ptr] <= res_data_i;
      buf_vd[wr_ptr]   <= res_vd_i;
      buf_sat[wr_ptr]  <= |res_sat_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
      req_q  <= 1'b0;
      wait_q <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= ~wr_ptr;
      end
      if (pop) begin
        rd_ptr <= ~rd_ptr;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // Four-phase sequence: req, ack, drop req, wait for ack low
      if (pop) begin
        req_q  <= 1'b0;
        wait_q <= 1'b1;
      end else if (wait_q && !rt_ack_i) begin
        wait_q <= 1'b0;
      end else if (!req_q && !wait_q && (count != 2'd0)) begin
        req_q <= 1'b1;
      end
    end
  end

  assign rt_req_o   = req_q;
  assign rt_data_o  = buf_data[rd_ptr];
  assign rt_vd_o    = buf_vd[rd_ptr];
  assign rt_vxsat_o = buf_sat[rd_ptr];

  // Record held steady until the consumer acks
  a_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
    rt_req_o && !rt_ack_i |=> rt_req_o && $stable(rt_data_o) && $stable(rt_vd_o)
      && $stable(rt_vxsat_o));

  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> (count != 2'd2));

endmodule

//--- rtl/vec_lane.sv
`timescale 1ns/100ps

module vec_lane (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               issue_valid_i,
  input  logic               lane_en_i,
  input  vec_pkg::vfunct_t   issue_funct_i,
  input  vec_pkg::vreg_idx_t issue_vd_i,
  input  vec_pkg::vreg_idx_t issue_vs1_i,
  input  vec_pkg::vreg_idx_t issue_vs2_i,
  input  vec_pkg::elem_t     issue_imm_i,
  output logic               res_valid_o,
  output vec_pkg::elem_t     res_elem_o,
  output logic               res_sat_o
);

  import vec_pkg::*;

  elem_t           vreg [num_vregs];
  elem_t           op_a;
  elem_t           op_b;
  elem_t           old_d;
  logic [elem_w:0] sum_w;
  logic [elem_w:0] diff_w;
  elem_t           alu_res;
  logic            alu_sat;
  logic            wr_en;

  // Register slice reads are combinational
  assign op_a  = vreg[issue_vs1_i];
  assign op_b  = vreg[issue_vs2_i];
  assign old_d = vreg[issue_vd_i];

  // Extra top bit is the carry or the borrow
  assign sum_w  = {1'b0, op_a} + {1'b0, op_b};
  assign diff_w = {1'b0, op_a} - {1'b0, op_b};

  assign wr_en = issue_valid_i && lane_en_i;

  always_comb begin
    alu_res = old_d;
    alu_sat = 1'b0;
    case (issue_funct_i)
      VADD: begin
        alu_res = sum_w[elem_w-1:0];
      end
      VSADDU: begin
        alu_sat = sum_w[elem_w];
        alu_res = alu_sat ? '1 : sum_w[elem_w-1:0];
      end
      // Floors at zero when vs2 exceeds vs1
      VSSUBU: begin
        alu_sat = diff_w[elem_w];
        alu_res = alu_sat ? '0 : diff_w[elem_w-1:0];
      end
      VMVI: begin
        alu_res = issue_imm_i;
      end
      default: begin
        alu_res = old_d;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < num_vregs; i++) begin
        vreg[i] <= '0;
      end
    end else if (wr_en) begin
      vreg[issue_vd_i] <= alu_res;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res_valid_o <= 1'b0;
      res_sat_o   <= 1'b0;
    end else begin
      res_valid_o <= issue_valid_i;
      res_sat_o   <= wr_en && alu_sat;
    end
  end

  // Tail lanes report the untouched destination
  always_ff @(posedge clk) begin
    if (issue_valid_i) begin
      res_elem_o <= wr_en ? alu_res : old_d;
    end
  end

  // A saturated result is a clamped value from an enabled lane
  a_sat_only_enabled: assert property (@(posedge clk) disable iff (!rst_n)
    res_sat_o |-> $past(lane_en_i) && ((res_elem_o == '1) || (res_elem_o == '0)));

endmodule

//--- rtl/vec_dispatch.sv
`timescale 1ns/100ps

module vec_dispatch (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          q_valid_i,
  input  vec_pkg::vinst_u               q_inst_i,
  output logic                          q_pop_o,
  input  logic                          rt_space_i,
  output logic                          issue_valid_o,
  output vec_pkg::vfunct_t              issue_funct_o,
  output vec_pkg::vreg_idx_t            issue_vd_o,
  output vec_pkg::vreg_idx_t            issue_vs1_o,
  output vec_pkg::vreg_idx_t            issue_vs2_o,
  output vec_pkg::elem_t                issue_imm_o,
  output logic [vec_pkg::num_lanes-1:0] lane_en_o
);

  import vec_pkg::*;

  logic is_cfg;
  logic cfg_pop;
  logic arith_go;
  vl_t  vl_new;
  vl_t  vl_q;

  // Kind bit sits at the same place in both views
  assign is_cfg = q_inst_i.cfg.kind;

  // Requested length clamped to the lane count
  assign vl_new = (q_inst_i.cfg.vl > vl_max) ? vl_max : q_inst_i.cfg.vl;

  // Config words never wait; arithmetic waits for retire room
  assign cfg_pop  = q_valid_i && is_cfg;
  assign arith_go = q_valid_i && !is_cfg && rt_space_i;

  assign q_pop_o       = cfg_pop || arith_go;
  assign issue_valid_o = arith_go;

  // Operand fields broadcast straight from the head entry
  assign issue_funct_o = q_inst_i.arith.funct;
  assign issue_vd_o    = q_inst_i.arith.vd;
  assign issue_vs1_o   = q_inst_i.arith.vs1;
  assign issue_vs2_o   = q_inst_i.arith.vs2;
  assign issue_imm_o   = q_inst_i.arith.imm;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vl_q <= vl_max;
    end else if (cfg_pop) begin
      vl_q <= vl_new;
    end
  end

  // Lane i is active when i < vl
  always_comb begin
    for (int i = 0; i < num_lanes; i++) begin
      lane_en_o[i] = (vl_t'(i) < vl_q);
    end
  end

endmodule

//--- rtl/vec_cmd_queue.sv
`timescale 1ns/100ps

module vec_cmd_queue (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            inst_req_i,
  input  vec_pkg::vinst_u inst_i,
  output logic            inst_ack_o,
  input  logic            q_pop_i,
  output logic            q_valid_o,
  output vec_pkg::vinst_u q_inst_o,
  output logic            q_empty_o
);

  import vec_pkg::*;

  vinst_u             mem [q_depth];
  logic [q_ptr_w-1:0] wr_ptr;
  logic [q_ptr_w-1:0] rd_ptr;
  logic [q_ptr_w:0]   count;
  logic               full;
  logic               ack_q;
  logic               push;

  assign full = (count == q_full_cnt);

  // One capture per request while ack is low
  assign push = inst_req_i && !ack_q && !full;

  // Intake handshake state lives in the ack flop
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
    end else if (push) begin
      ack_q <= 1'b1;
    end else if (ack_q && !inst_req_i) begin
      ack_q <= 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (q_pop_i) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, q_pop_i})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= inst_i;
    end
  end

  assign inst_ack_o = ack_q;
  assign q_valid_o  = (count != '0);
  assign q_empty_o  = (count == '0);
  assign q_inst_o   = mem[rd_ptr];

  // A full queue neither writes nor acknowledges
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    full |=> $stable(wr_ptr) && !$rose(inst_ack_o));

  // Dispatch must only consume a valid head
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
    q_pop_i |-> q_valid_o);

endmodule

//--- rtl/vec_pkg.sv
package vec_pkg;

  // Datapath sizing
  localparam int num_lanes = 4;
  localparam int elem_w    = 8;
  localparam int num_vregs = 8;
  localparam int vreg_w    = $clog2(num_vregs);

  // Command queue sizing
  localparam int q_depth = 4;
  localparam int q_ptr_w = $clog2(q_depth);
  localparam logic [q_ptr_w:0] q_full_cnt = (q_ptr_w + 1)'(q_depth);

  typedef logic [vreg_w-1:0]           vreg_idx_t;
  typedef logic [elem_w-1:0]           elem_t;
  typedef logic [num_lanes*elem_w-1:0] elem_vec_t;
  typedef logic [2:0]                  vl_t;

  // Largest legal vector length
  localparam vl_t vl_max = vl_t'(num_lanes);

  typedef enum logic [2:0] {
    VADD   = 3'd0,
    VSADDU = 3'd1,
    VSSUBU = 3'd2,
    VMVI   = 3'd3
  } vfunct_t;

  // One instruction word, split by the kind bit in bit 23
  typedef union packed {
    // Arithmetic view, kind = 0
    struct packed {
      logic       kind;
      vfunct_t    funct;
      vreg_idx_t  vd;
      vreg_idx_t  vs1;
      vreg_idx_t  vs2;
      logic [2:0] spare;
      elem_t      imm;
    } arith;
    // Configuration view, kind = 1
    struct packed {
      logic        kind;
      logic [19:0] spare;
      vl_t         vl;
    } cfg;
  } vinst_u;

endpackage
